// File: logic/dac_instr_queue.sv
module dac_instr_queue #(
	parameter int N_CH = 4
) (
	input  logic						clk50,
	input  logic						rst_n,
	input  pid_data_pkg::dac_word_t		out_word,
	input  pid_data_pkg::chan_t			out_chan,
	input  logic						out_valid,
	input  logic						dac_ack,
	output pid_data_pkg::dac_word_t		dac_data,
	output pid_data_pkg::chan_t			dac_chan,
	output logic						dac_valid
);

	localparam int W_IDX = (N_CH > 1) ? $clog2(N_CH) : 1;

	typedef enum logic {
		Q_IDLE,	// nothing presented
		Q_SEND	// holding register waits for dac_ack
	} q_state_t;

	q_state_t					state;
	pid_data_pkg::dac_word_t	store [N_CH];	// latest word per channel
	logic [N_CH-1:0]			pending;		// stored but not yet presented
	logic [N_CH-1:0]			pend_in;		// pending plus this cycle's arrival
	logic [W_IDX-1:0]			in_idx;
	logic [W_IDX-1:0]			sel;			// lowest pending channel
	logic						found;
	logic						take;			// holding register free this cycle

	assign in_idx    = out_chan[W_IDX-1:0];
	assign take      = (state == Q_IDLE) || dac_ack;
	assign dac_valid = (state == Q_SEND);

	always_comb begin
		pend_in = pending;
		if (out_valid)
			pend_in[in_idx] = 1'b1;	// new word, bypasses the store when idle
	end

	// priority pick, lowest channel wins
	always_comb begin
		found = 1'b0;
		sel   = '0;
		for (int i = N_CH - 1; i >= 0; i--) begin
			if (pend_in[i]) begin
				found = 1'b1;
				sel   = W_IDX'(i);
			end
		end
	end

	//////////////////////////////////////////////////
	// presentation control
	//////////////////////////////////////////////////

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			state   <= Q_IDLE;
			pending <= '0;
		end else if (take && found) begin
			state   <= Q_SEND;
			// bit drops on load, a rewrite while waiting for ack sets it again
			pending <= pend_in & ~(N_CH'(1) << sel);
		end else begin
			if (take)
				state <= Q_IDLE;	// acked and nothing left
			pending <= pend_in;
		end
	end

	always_ff @(posedge clk50) begin
		if (out_valid)
			store[in_idx] <= out_word;	// overwrites an unsent word
		if (take && found) begin
			dac_data <= (out_valid && in_idx == sel) ? out_word : store[sel];
			dac_chan <= pid_data_pkg::chan_t'(sel);
		end
	end

endmodule

// File: logic/output_preprocessor.sv
module output_preprocessor (
	input  logic						clk50,
	input  logic						rst_n,
	input  pid_data_pkg::comp_t			pid_sum,
	input  pid_data_pkg::chan_t			pid_chan,
	input  logic						pid_valid,
	input  pid_data_pkg::dac_word_t		out_min,
	input  pid_data_pkg::dac_word_t		out_max,
	input  pid_data_pkg::dac_word_t		out_init,
	input  pid_data_pkg::mult_t			mult,
	output pid_data_pkg::dac_word_t		out_word,
	output pid_data_pkg::chan_t			out_chan,
	output logic						out_valid
);

	pid_data_pkg::wide_t		scaled;	// pid_sum * mult
	pid_data_pkg::wide_t		total;	// plus offset
	pid_data_pkg::dac_word_t	clamped;

	// mult is unsigned, so pad a zero before going signed
	assign scaled = pid_data_pkg::wide_t'(pid_sum) * pid_data_pkg::wide_t'({1'b0, mult});
	assign total  = pid_data_pkg::wide_t'(out_init) + scaled;

	// saturate into [out_min, out_max]
	always_comb begin
		if (total < pid_data_pkg::wide_t'(out_min))
			clamped = out_min;
		else if (total > pid_data_pkg::wide_t'(out_max))
			clamped = out_max;
		else
			clamped = pid_data_pkg::dac_word_t'(total);	// in range, low bits exact
	end

	always_ff @(posedge clk50) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= pid_valid;
	end

	always_ff @(posedge clk50) begin
		if (pid_valid) begin
			out_word <= clamped;
			out_chan <= pid_chan;
		end
	end

endmodule

// File: logic/oversample_filter.sv
module oversample_filter #(
	parameter int N_CH = 4
) (
	input  logic						clk50,
	input  logic						rst_n,
	input  pid_reg_pkg::osm_t			osm,
	input  pid_data_pkg::adc_word_t		sample_data,
	input  pid_data_pkg::chan_t			sample_chan,
	input  logic						sample_valid,
	output pid_data_pkg::adc_word_t		avg_data,
	output pid_data_pkg::chan_t			avg_chan,
	output logic						avg_valid
);

	localparam int W_IDX = (N_CH > 1) ? $clog2(N_CH) : 1;	// channel index width

	pid_data_pkg::acc_t		acc [N_CH];	// running window sums
	pid_data_pkg::win_cnt_t	cnt [N_CH];	// samples already in each window
	logic [W_IDX-1:0]		idx;
	pid_data_pkg::acc_t		sum_nxt;
	pid_data_pkg::win_cnt_t	win_len;
	logic					last;		// this sample closes its channel's window

	assign idx     = sample_chan[W_IDX-1:0];
	assign sum_nxt = acc[idx] + pid_data_pkg::acc_t'(sample_data);	// sign-extended add
	assign win_len = pid_data_pkg::win_cnt_t'(1) << osm;
	assign last    = (cnt[idx] + pid_data_pkg::win_cnt_t'(1)) == win_len;

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			avg_valid <= 1'b0;
			for (int i = 0; i < N_CH; i++) begin
				acc[i] <= '0;
				cnt[i] <= '0;
			end
		end else begin
			avg_valid <= sample_valid && last;
			if (sample_valid) begin
				if (last) begin
					// window done, start the next one empty
					acc[idx] <= '0;
					cnt[idx] <= '0;
				end else begin
					acc[idx] <= sum_nxt;
					cnt[idx] <= cnt[idx] + pid_data_pkg::win_cnt_t'(1);
				end
			end
		end
	end

	// average = sum / 2^osm, arithmetic shift keeps the sign
	always_ff @(posedge clk50) begin
		if (sample_valid && last) begin
			avg_data <= pid_data_pkg::adc_word_t'(sum_nxt >>> osm);
			avg_chan <= sample_chan;
		end
	end

endmodule

// File: logic/pid_controller.sv
module pid_controller #(
	parameter int N_CH = 4	// 1 to 8 channels
) (
	input  logic						clk50,
	input  logic						rst_n,
	// wishbone register port
	input  logic						wb_cyc,
	input  logic						wb_stb,
	input  logic						wb_we,
	input  pid_reg_pkg::reg_addr_t		wb_adr,
	input  pid_reg_pkg::wb_data_t		wb_dat_w,
	output pid_reg_pkg::wb_data_t		wb_dat_r,
	output logic						wb_ack,
	// sample input, no back-pressure
	input  pid_data_pkg::adc_word_t		sample_data,
	input  pid_data_pkg::chan_t			sample_chan,
	input  logic						sample_valid,
	// dac word output
	output pid_data_pkg::dac_word_t		dac_data,
	output pid_data_pkg::chan_t			dac_chan,
	output logic						dac_valid,
	input  logic						dac_ack
);

	// settings from the register block
	pid_data_pkg::coef_t		setpoint;
	pid_data_pkg::coef_t		p_coef;
	pid_data_pkg::coef_t		i_coef;
	pid_data_pkg::coef_t		d_coef;
	pid_reg_pkg::osm_t			osm;
	logic [N_CH-1:0]			lock_en;
	logic [N_CH-1:0]			clear;	// one-cycle pulses
	pid_data_pkg::dac_word_t	out_min;
	pid_data_pkg::dac_word_t	out_max;
	pid_data_pkg::dac_word_t	out_init;
	pid_data_pkg::mult_t		mult;

	// pipeline between stages
	pid_data_pkg::adc_word_t	avg_data;
	pid_data_pkg::chan_t		avg_chan;
	logic						avg_valid;
	pid_data_pkg::comp_t		pid_sum;
	pid_data_pkg::chan_t		pid_chan;
	logic						pid_valid;
	pid_data_pkg::dac_word_t	out_word;
	pid_data_pkg::chan_t		out_chan;
	logic						out_valid;

	// every port below matches a signal of the same name
	wb_reg_decode #(.N_CH(N_CH)) decode_inst (.*);	// decode

	oversample_filter #(.N_CH(N_CH)) osf_inst (.*);	// execute
	pid_core #(.N_CH(N_CH)) pid_inst (.*);

	output_preprocessor opp_inst (.*);				// result
	dac_instr_queue #(.N_CH(N_CH)) diq_inst (.*);

endmodule

// File: logic/pid_core.sv
module pid_core #(
	parameter int N_CH = 4
) (
	input  logic						clk50,
	input  logic						rst_n,
	input  pid_data_pkg::adc_word_t		avg_data,
	input  pid_data_pkg::chan_t			avg_chan,
	input  logic						avg_valid,
	input  pid_data_pkg::coef_t			setpoint,
	input  pid_data_pkg::coef_t			p_coef,
	input  pid_data_pkg::coef_t			i_coef,
	input  pid_data_pkg::coef_t			d_coef,
	input  logic [N_CH-1:0]				lock_en,
	input  logic [N_CH-1:0]				clear,
	output pid_data_pkg::comp_t			pid_sum,
	output pid_data_pkg::chan_t			pid_chan,
	output logic						pid_valid
);

	localparam int W_IDX = (N_CH > 1) ? $clog2(N_CH) : 1;

	pid_data_pkg::comp_t	integ [N_CH];		// per-channel integrator
	pid_data_pkg::comp_t	prev_err [N_CH];	// per-channel last error
	logic [W_IDX-1:0]		idx;
	pid_data_pkg::comp_t	err;
	pid_data_pkg::comp_t	integ_nxt;

	// stage 1 results
	pid_data_pkg::comp_t	s1_err;
	pid_data_pkg::comp_t	s1_integ;
	pid_data_pkg::comp_t	s1_diff;	// error - previous error
	pid_data_pkg::chan_t	s1_chan;
	logic					s1_zero;	// channel unlocked or being cleared
	logic					s1_valid;

	assign idx = avg_chan[W_IDX-1:0];
	// setpoint widened to sample width, then both to computation width
	assign err = pid_data_pkg::comp_t'(pid_data_pkg::adc_word_t'(setpoint))
		- pid_data_pkg::comp_t'(avg_data);
	assign integ_nxt = integ[idx] + err;

	//////////////////////////////////////////////////
	// stage 1: error and state update
	//////////////////////////////////////////////////

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			for (int i = 0; i < N_CH; i++) begin
				integ[i]    <= '0;
				prev_err[i] <= '0;
			end
		end else begin
			s1_valid <= avg_valid;
			for (int i = 0; i < N_CH; i++) begin
				if (!lock_en[i] || clear[i]) begin	// hold state at zero
					integ[i]    <= '0;
					prev_err[i] <= '0;
				end else if (avg_valid && idx == W_IDX'(i)) begin
					integ[i]    <= integ_nxt;
					prev_err[i] <= err;
				end
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (avg_valid) begin
			s1_err   <= err;
			s1_integ <= integ_nxt;	// i term sees this sample's error
			s1_diff  <= err - prev_err[idx];
			s1_chan  <= avg_chan;
			s1_zero  <= !lock_en[idx] || clear[idx];
		end
	end

	//////////////////////////////////////////////////
	// stage 2: p, i and d products summed
	//////////////////////////////////////////////////

	always_ff @(posedge clk50) begin
		if (!rst_n)
			pid_valid <= 1'b0;
		else
			pid_valid <= s1_valid;
	end

	always_ff @(posedge clk50) begin
		if (s1_valid) begin
			pid_chan <= s1_chan;
			if (s1_zero)
				pid_sum <= '0;	// unlocked channel sits at out_init
			else
				pid_sum <= pid_data_pkg::comp_t'(p_coef) * s1_err
					+ pid_data_pkg::comp_t'(i_coef) * s1_integ
					+ pid_data_pkg::comp_t'(d_coef) * s1_diff;
		end
	end

endmodule

// File: logic/pid_data_pkg.sv
package pid_data_pkg;

	//////////////////////////////////////////////////
	// datapath words
	//////////////////////////////////////////////////

	typedef logic signed [17:0]	adc_word_t;	// adc sample, two's complement
	typedef logic signed [15:0]	coef_t;		// setpoint and pid gains
	typedef logic signed [47:0]	comp_t;		// pid computation word
	typedef logic [15:0]		dac_word_t;	// unsigned dac code
	typedef logic [7:0]			mult_t;		// output multiplier
	typedef logic [2:0]			chan_t;		// up to 8 channels

	// oversample filter sizing
	localparam int OSM_MAX = 4;	// largest legal osm, 16 sample window
	typedef logic signed [$bits(adc_word_t)+OSM_MAX-1:0] acc_t;	// window sum
	typedef logic [OSM_MAX:0] win_cnt_t;	// holds 2^OSM_MAX

	// wide enough that scale and offset never wrap
	typedef logic signed [63:0] wide_t;

	//////////////////////////////////////////////////
	// pipeline latencies in clk50 cycles
	//////////////////////////////////////////////////

	localparam int OSF_LATENCY = 1;
	localparam int PID_LATENCY = 2;	// error/state stage then multiply-add stage
	localparam int OPP_LATENCY = 1;
	localparam int DIQ_LATENCY = 1;	// idle queue only

	// last window sample to dac_valid
	localparam int PIPE_LATENCY = OSF_LATENCY + PID_LATENCY + OPP_LATENCY + DIQ_LATENCY;

endpackage

// File: logic/pid_reg_pkg.sv
package pid_reg_pkg;

	//////////////////////////////////////////////////
	// bus and field types
	//////////////////////////////////////////////////

	typedef logic [3:0]		reg_addr_t;	// wishbone word address
	typedef logic [15:0]	wb_data_t;	// wishbone data word
	typedef logic [2:0]		osm_t;		// log2 of averaging count, 0 to 4 legal

	// register map
	localparam reg_addr_t ADDR_SETPOINT	= 4'd0;
	localparam reg_addr_t ADDR_P_COEF	= 4'd1;
	localparam reg_addr_t ADDR_I_COEF	= 4'd2;
	localparam reg_addr_t ADDR_D_COEF	= 4'd3;
	localparam reg_addr_t ADDR_OSM		= 4'd4;
	localparam reg_addr_t ADDR_OUT_MIN	= 4'd5;
	localparam reg_addr_t ADDR_OUT_MAX	= 4'd6;
	localparam reg_addr_t ADDR_OUT_INIT	= 4'd7;
	localparam reg_addr_t ADDR_MULT		= 4'd8;
	localparam reg_addr_t ADDR_LOCK		= 4'd9;
	localparam reg_addr_t ADDR_CLEAR	= 4'd10;	// write-only pulse register

	// values loaded by reset
	localparam wb_data_t RST_SETPOINT	= 16'd0;
	localparam wb_data_t RST_P_COEF		= 16'd1;
	localparam wb_data_t RST_I_COEF		= 16'd0;
	localparam wb_data_t RST_D_COEF		= 16'd0;
	localparam osm_t     RST_OSM		= 3'd0;	// no averaging
	localparam wb_data_t RST_OUT_MIN	= 16'd0;
	localparam wb_data_t RST_OUT_MAX	= 16'd65535;
	localparam wb_data_t RST_OUT_INIT	= 16'd32768;	// dac mid-scale
	localparam wb_data_t RST_MULT		= 16'd1;
	localparam wb_data_t RST_LOCK		= 16'd0;	// all channels unlocked

endpackage

// File: logic/wb_reg_decode.sv
module wb_reg_decode #(
	parameter int N_CH = 4
) (
	input  logic						clk50,
	input  logic						rst_n,
	input  logic						wb_cyc,
	input  logic						wb_stb,
	input  logic						wb_we,
	input  pid_reg_pkg::reg_addr_t		wb_adr,
	input  pid_reg_pkg::wb_data_t		wb_dat_w,
	output pid_reg_pkg::wb_data_t		wb_dat_r,
	output logic						wb_ack,
	output pid_data_pkg::coef_t			setpoint,
	output pid_data_pkg::coef_t			p_coef,
	output pid_data_pkg::coef_t			i_coef,
	output pid_data_pkg::coef_t			d_coef,
	output pid_reg_pkg::osm_t			osm,
	output logic [N_CH-1:0]				lock_en,
	output logic [N_CH-1:0]				clear,
	output pid_data_pkg::dac_word_t		out_min,
	output pid_data_pkg::dac_word_t		out_max,
	output pid_data_pkg::dac_word_t		out_init,
	output pid_data_pkg::mult_t			mult
);

	logic					req;	// fresh cycle, ack not yet given
	logic					wr;
	pid_reg_pkg::wb_data_t	rd_mux;

	assign req = wb_cyc && wb_stb && !wb_ack;
	assign wr  = req && wb_we;

	// readback, clear and unmapped words read as zero
	always_comb begin
		case (wb_adr)
			pid_reg_pkg::ADDR_SETPOINT:	rd_mux = pid_reg_pkg::wb_data_t'(setpoint);
			pid_reg_pkg::ADDR_P_COEF:	rd_mux = pid_reg_pkg::wb_data_t'(p_coef);
			pid_reg_pkg::ADDR_I_COEF:	rd_mux = pid_reg_pkg::wb_data_t'(i_coef);
			pid_reg_pkg::ADDR_D_COEF:	rd_mux = pid_reg_pkg::wb_data_t'(d_coef);
			pid_reg_pkg::ADDR_OSM:		rd_mux = pid_reg_pkg::wb_data_t'(osm);
			pid_reg_pkg::ADDR_OUT_MIN:	rd_mux = out_min;
			pid_reg_pkg::ADDR_OUT_MAX:	rd_mux = out_max;
			pid_reg_pkg::ADDR_OUT_INIT:	rd_mux = out_init;
			pid_reg_pkg::ADDR_MULT:		rd_mux = pid_reg_pkg::wb_data_t'(mult);
			pid_reg_pkg::ADDR_LOCK:		rd_mux = pid_reg_pkg::wb_data_t'(lock_en);
			default:					rd_mux = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// tuning registers, written on the ack edge
	//////////////////////////////////////////////////

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			wb_ack   <= 1'b0;
			clear    <= '0;
			setpoint <= pid_data_pkg::coef_t'(pid_reg_pkg::RST_SETPOINT);
			p_coef   <= pid_data_pkg::coef_t'(pid_reg_pkg::RST_P_COEF);
			i_coef   <= pid_data_pkg::coef_t'(pid_reg_pkg::RST_I_COEF);
			d_coef   <= pid_data_pkg::coef_t'(pid_reg_pkg::RST_D_COEF);
			osm      <= pid_reg_pkg::RST_OSM;
			out_min  <= pid_reg_pkg::RST_OUT_MIN;
			out_max  <= pid_reg_pkg::RST_OUT_MAX;
			out_init <= pid_reg_pkg::RST_OUT_INIT;
			mult     <= pid_data_pkg::mult_t'(pid_reg_pkg::RST_MULT);
			lock_en  <= pid_reg_pkg::RST_LOCK[N_CH-1:0];
		end else begin
			wb_ack <= req;	// single-cycle ack
			clear  <= '0;	// clear bits live one cycle only
			if (wr) begin
				case (wb_adr)
					pid_reg_pkg::ADDR_SETPOINT:	setpoint <= pid_data_pkg::coef_t'(wb_dat_w);
					pid_reg_pkg::ADDR_P_COEF:	p_coef   <= pid_data_pkg::coef_t'(wb_dat_w);
					pid_reg_pkg::ADDR_I_COEF:	i_coef   <= pid_data_pkg::coef_t'(wb_dat_w);
					pid_reg_pkg::ADDR_D_COEF:	d_coef   <= pid_data_pkg::coef_t'(wb_dat_w);
					pid_reg_pkg::ADDR_OSM:		osm      <= pid_reg_pkg::osm_t'(wb_dat_w);
					pid_reg_pkg::ADDR_OUT_MIN:	out_min  <= wb_dat_w;
					pid_reg_pkg::ADDR_OUT_MAX:	out_max  <= wb_dat_w;
					pid_reg_pkg::ADDR_OUT_INIT:	out_init <= wb_dat_w;
					pid_reg_pkg::ADDR_MULT:		mult     <= pid_data_pkg::mult_t'(wb_dat_w);
					pid_reg_pkg::ADDR_LOCK:		lock_en  <= wb_dat_w[N_CH-1:0];
					pid_reg_pkg::ADDR_CLEAR:	clear    <= wb_dat_w[N_CH-1:0];
					default: ;	// unmapped, write dropped
				endcase
			end
		end
	end

	// read data lines up with the ack
	always_ff @(posedge clk50) begin
		if (req)
			wb_dat_r <= rd_mux;
	end

endmodule

// File: pid_controller.f
logic/pid_reg_pkg.sv
logic/pid_data_pkg.sv
logic/wb_reg_decode.sv
logic/oversample_filter.sv
logic/pid_core.sv
logic/output_preprocessor.sv
logic/dac_instr_queue.sv
logic/pid_controller.sv
verif/pid_controller_props.sv
verif/pid_controller_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --assert -Wno-fatal -f pid_controller.f --top-module pid_controller_tb \
	-o pid_sim && ./obj_dir/pid_sim | tee /dev/stderr | grep -qx "test passed" \
	&& echo "simulation ok" || { echo "simulation not ok"; exit 1; }

// File: verif/pid_controller_props.sv
module pid_controller_props #(
	parameter int N_CH = 4
) (
	input logic							clk50,
	input logic							rst_n,
	input logic							wb_cyc,
	input logic							wb_stb,
	input logic							wb_ack,
	input pid_data_pkg::dac_word_t		dac_data,
	input pid_data_pkg::chan_t			dac_chan,
	input logic							dac_valid,
	input logic							dac_ack
);
	timeunit 1ns;
	timeprecision 100ps;

	//////////////////////////////////////////////////
	// wishbone ack
	//////////////////////////////////////////////////

	ack_after_req: assert property (@(posedge clk50) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb)) else $error("ack without cyc and stb");
	ack_one_cycle: assert property (@(posedge clk50) disable iff (!rst_n)
		wb_ack |=> !wb_ack) else $error("ack high two cycles");

	//////////////////////////////////////////////////
	// dac handshake
	//////////////////////////////////////////////////

	dac_hold: assert property (@(posedge clk50) disable iff (!rst_n)
		dac_valid && !dac_ack |=> dac_valid && $stable(dac_data) && $stable(dac_chan))
		else $error("dac word changed before ack");
	dac_chan_range: assert property (@(posedge clk50) disable iff (!rst_n)
		dac_valid |-> dac_chan < N_CH) else $error("dac channel out of range");
	dac_reset: assert property (@(posedge clk50)
		!rst_n |=> !dac_valid) else $error("dac_valid high after reset");	// checked every reset cycle

endmodule

bind pid_controller pid_controller_props #(.N_CH(N_CH)) props_inst (.*);

// File: verif/pid_controller_tb.sv
module pid_controller_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_CH = 4;

	logic clk50;
	logic rst_n;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	logic sample_valid;
	logic dac_valid, dac_ack;
	pid_reg_pkg::reg_addr_t		wb_adr;
	pid_reg_pkg::wb_data_t		wb_dat_w, wb_dat_r;
	pid_data_pkg::adc_word_t	sample_data;
	pid_data_pkg::chan_t		sample_chan, dac_chan;
	pid_data_pkg::dac_word_t	dac_data;

	int errors = 0;
	logic [31:0] rng = 32'd20;	// xorshift state
	logic overwrite = 1'b0;		// latest-value mode for back-pressure
	logic [15:0] exp_q [N_CH][$];	// expected dac words per channel
	int order_q [$];				// expected channel order, when used
	int hold_cnt [N_CH];			// words already latched in the holding register

	// reference model state, mirrors the registers
	int m_sp, m_p, m_i, m_d, m_osm, m_min, m_max, m_init, m_mult;
	logic [N_CH-1:0] m_lock;
	longint m_integ [N_CH], m_prev [N_CH], m_acc [N_CH];
	int m_cnt [N_CH];

	pid_controller #(.N_CH(N_CH)) pid_controller_inst (.*);

	initial begin
		clk50 = 1'b0;
		forever #4 clk50 = ~clk50;
	end

	function automatic int rand_sample(int limit);
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return int'(rng % (2 * limit + 1)) - limit;
	endfunction

	//////////////////////////////////////////////////
	// reference model of pid then scale, offset and clamp
	//////////////////////////////////////////////////

	function automatic logic [15:0] ref_out(int ch, longint avg);
		longint err, diff, sum, total;
		sum = 0;
		if (!m_lock[ch]) begin
			m_integ[ch] = 0;	// unlocked, state held at zero
			m_prev[ch] = 0;
		end else begin
			err = longint'(m_sp) - avg;
			m_integ[ch] = m_integ[ch] + err;	// i term includes this error
			diff = err - m_prev[ch];
			m_prev[ch] = err;
			sum = m_p * err + m_i * m_integ[ch] + m_d * diff;
		end
		total = longint'(m_init) + sum * longint'(m_mult);
		if (total < m_min)
			return 16'(m_min);
		if (total > m_max)
			return 16'(m_max);
		return 16'(total);
	endfunction

	task automatic push_expected(int ch, logic [15:0] w);
		if (overwrite && exp_q[ch].size() > hold_cnt[ch])
			exp_q[ch][exp_q[ch].size() - 1] = w;	// unsent word replaced
		else
			exp_q[ch].push_back(w);
	endtask

	task automatic timeout_fail(string msg);
		$display("timeout while %s, errors: %0d", msg, errors);
		$display("test failed");
		$finish;
	endtask

	task automatic wb_cycle(logic we, logic [3:0] adr, logic [15:0] dw, output logic [15:0] dr);
		int n;
		@(posedge clk50);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dw;
		for (n = 0; n < 20 && !wb_ack; n++) begin
			@(posedge clk50);
			#1;
		end
		if (!wb_ack)
			timeout_fail("waiting for wb_ack");
		dr = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	// write a register and keep the model in step
	task automatic set_reg(logic [3:0] adr, logic [15:0] val);
		logic [15:0] dummy;
		wb_cycle(1'b1, adr, val, dummy);
		case (adr)
			0: m_sp = int'($signed(val));
			1: m_p = int'($signed(val));
			2: m_i = int'($signed(val));
			3: m_d = int'($signed(val));
			4: m_osm = int'(val[2:0]);
			5: m_min = int'(val);
			6: m_max = int'(val);
			7: m_init = int'(val);
			8: m_mult = int'(val[7:0]);
			9: m_lock = val[N_CH-1:0];
			default: ;
		endcase
		for (int c = 0; c < N_CH; c++) begin
			if ((adr == 4'd9 && !val[c]) || (adr == 4'd10 && val[c])) begin
				m_integ[c] = 0;
				m_prev[c] = 0;
			end
		end
	endtask

	task automatic check_reg(logic [3:0] adr, logic [15:0] exp);
		logic [15:0] got;
		wb_cycle(1'b0, adr, 16'h0, got);
		if (got !== exp) begin
			$display("FAILED at %0t: reg %0d read %h, expected %h", $time, adr, got, exp);
			errors++;
		end
	endtask

	// one sample per call, back to back when called in a row
	task automatic send_sample(int ch, int val);
		longint avg;
		@(posedge clk50);
		#1;
		sample_data = pid_data_pkg::adc_word_t'(val);
		sample_chan = pid_data_pkg::chan_t'(ch);
		sample_valid = 1'b1;
		m_acc[ch] = m_acc[ch] + val;
		m_cnt[ch]++;
		if (m_cnt[ch] == (1 << m_osm)) begin	// window closes
			avg = m_acc[ch] >>> m_osm;
			m_acc[ch] = 0;
			m_cnt[ch] = 0;
			push_expected(ch, ref_out(ch, avg));
		end
	endtask

	task automatic sample_idle();
		@(posedge clk50);
		#1 sample_valid = 1'b0;
	endtask

	function automatic logic all_empty();
		for (int c = 0; c < N_CH; c++)
			if (exp_q[c].size() != 0)
				return 1'b0;
		return order_q.size() == 0;
	endfunction

	task automatic wait_drain();
		int n;
		for (n = 0; n < 300 && !(all_empty() && !dac_valid); n++) begin
			@(posedge clk50);
			#1;
		end
		if (!(all_empty() && !dac_valid))
			timeout_fail("waiting for expected dac words");
	endtask

	//////////////////////////////////////////////////
	// compare on every dac handshake
	//////////////////////////////////////////////////

	always @(negedge clk50) begin : compare
		int c;
		logic [15:0] exp;
		if (rst_n && dac_valid && dac_ack) begin
			c = int'(dac_chan);
			if (c >= N_CH || exp_q[c].size() == 0) begin
				$display("unexpected dac word %h on channel %0d at %0t", dac_data, c, $time);
				errors++;
			end else begin
				exp = exp_q[c].pop_front();
				if (hold_cnt[c] > 0)
					hold_cnt[c]--;
				if (dac_data !== exp) begin
					$display("FAILED at %0t: chan %0d dac %h, expected %h", $time, c, dac_data, exp);
					errors++;
				end
			end
			if (order_q.size() > 0 && order_q.pop_front() != c) begin
				$display("FAILED at %0t: chan %0d out of order", $time, c);
				errors++;
			end
		end
	end

	initial begin
		int v;
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		sample_data = '0;
		sample_chan = '0;
		sample_valid = 1'b0;
		dac_ack = 1'b1;
		m_sp = 0;
		m_p = 1;
		m_i = 0;
		m_d = 0;
		m_osm = 0;
		m_min = 0;
		m_max = 65535;
		m_init = 32768;
		m_mult = 1;
		m_lock = '0;
		for (int c = 0; c < N_CH; c++) begin
			m_integ[c] = 0;
			m_prev[c] = 0;
			m_acc[c] = 0;
			m_cnt[c] = 0;
			hold_cnt[c] = 0;
		end
		repeat (16) @(posedge clk50);
		#1 rst_n = 1'b1;

		// reset values, readback and a clear register that reads zero
		check_reg(0, 16'd0);
		check_reg(1, 16'd1);
		check_reg(2, 16'd0);
		check_reg(3, 16'd0);
		check_reg(4, 16'd0);
		check_reg(5, 16'd0);
		check_reg(6, 16'd65535);
		check_reg(7, 16'd32768);
		check_reg(8, 16'd1);
		check_reg(9, 16'd0);
		set_reg(0, 16'hF123);
		set_reg(1, 16'h0456);
		set_reg(2, 16'h0789);
		set_reg(3, 16'h0ABC);
		set_reg(4, 16'h0003);
		set_reg(5, 16'h1111);
		set_reg(6, 16'hEEEE);
		set_reg(7, 16'h7777);
		set_reg(8, 16'h01A5);
		set_reg(9, 16'h00F6);
		check_reg(0, 16'hF123);
		check_reg(1, 16'h0456);
		check_reg(2, 16'h0789);
		check_reg(3, 16'h0ABC);
		check_reg(4, 16'h0003);
		check_reg(5, 16'h1111);
		check_reg(6, 16'hEEEE);
		check_reg(7, 16'h7777);
		check_reg(8, 16'h00A5);
		check_reg(9, 16'h0006);
		check_reg(10, 16'h0000);
		check_reg(11, 16'h0000);	// unmapped

		// with lock off the outputs sit at init and latency is timed from an idle queue
		set_reg(4, 0);
		set_reg(5, 0);
		set_reg(6, 65535);
		set_reg(7, 32768);
		set_reg(8, 1);
		set_reg(9, 0);
		set_reg(1, 1);
		set_reg(2, 0);
		set_reg(3, 0);
		send_sample(0, rand_sample(20000));
		for (int k = 1; k <= pid_data_pkg::PIPE_LATENCY; k++) begin
			@(posedge clk50);
			#1;
			sample_valid = 1'b0;
			if ((k < pid_data_pkg::PIPE_LATENCY) == dac_valid) begin
				$display("FAILED at %0t: dac_valid %b at cycle %0d", $time, dac_valid, k);
				errors++;
			end
		end
		wait_drain();
		for (int i = 0; i < 12; i++)
			send_sample(i % N_CH, rand_sample(20000));
		sample_idle();
		wait_drain();

		// proportional path with saturation at both ends
		set_reg(0, 16'd1000);
		set_reg(1, 16'd3);
		set_reg(8, 2);
		set_reg(5, 16'd1000);
		set_reg(6, 16'd60000);
		set_reg(9, 16'h000F);
		for (int i = 0; i < 32; i++)
			send_sample(i % N_CH, rand_sample(20000));
		sample_idle();
		wait_drain();

		// oversampling by four
		set_reg(4, 2);
		for (int i = 0; i < 32; i++)
			send_sample(i % N_CH, rand_sample(20000));
		sample_idle();
		wait_drain();

		// pi and pd over two channels from cleared state, channel 0 cleared again halfway
		set_reg(4, 0);
		set_reg(1, 2);
		set_reg(2, 1);
		set_reg(3, 3);
		set_reg(8, 1);
		set_reg(5, 0);
		set_reg(6, 65535);
		set_reg(10, 16'h000F);
		for (int i = 0; i < 12; i++)
			send_sample(i % 2, rand_sample(1000));
		sample_idle();
		wait_drain();
		set_reg(10, 16'h0001);
		for (int i = 0; i < 12; i++)
			send_sample(i % 2, rand_sample(1000));
		sample_idle();
		wait_drain();

		// channel 2 held under back-pressure while later words collapse to the latest
		dac_ack = 1'b0;
		send_sample(2, rand_sample(1000));
		sample_idle();
		for (v = 0; v < 20 && !dac_valid; v++) begin
			@(posedge clk50);
			#1;
		end
		if (!dac_valid)
			timeout_fail("waiting for dac_valid under back-pressure");
		hold_cnt[2] = 1;
		overwrite = 1'b1;
		for (int r = 0; r < 3; r++) begin
			send_sample(0, rand_sample(1000));
			send_sample(3, rand_sample(1000));
			send_sample(2, rand_sample(1000));
		end
		sample_idle();
		repeat (pid_data_pkg::PIPE_LATENCY + 4) @(posedge clk50);
		order_q = '{2, 0, 2, 3};	// held word first, then lowest pending
		#1 dac_ack = 1'b1;
		wait_drain();
		overwrite = 1'b0;

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule
